// ==== Bender.yml ====
package:
  name: sms_cart

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cart_pkg.sv
      - source/rom_write_if.sv
      - source/rom_read_if.sv
      - source/cart_loader.sv
      - source/rom_store.sv
      - source/cart_reader.sv
      - source/sms_cart_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/tb_sms_cart.sv

// ==== bench/tb_sms_cart.sv ====
/* Testbench for the cartridge path: downloads random images, reads them back
   through the console port and checks every response with concurrent assertions. */

`timescale 1ns/1ps
`include "cart_defs.svh"

module tb_sms_cart;

	localparam int burst_reads  = 64;
	localparam int sparse_reads = 32;
	localparam int read_phases  = 3;
	localparam int cheat_bytes  = 16;

	logic                 clk_sys;
	logic                 rst_n;
	logic                 ioctl_download;
	logic [7:0]           ioctl_index;
	logic                 ioctl_wr;
	cart_pkg::cart_addr_t ioctl_addr;
	cart_pkg::cart_byte_t ioctl_dout;
	logic                 ioctl_wait;
	logic                 gg;
	logic                 rom_rd;
	cart_pkg::cart_addr_t rom_a;
	cart_pkg::cart_byte_t rom_do;
	logic                 rom_rdy;

	cart_pkg::cart_byte_t model [1 << `CART_AW]; // Image as the store should hold it
	cart_pkg::cart_byte_t rd_exp [$];            // Expected bytes, oldest first
	cart_pkg::cart_byte_t exp_head;
	cart_pkg::cart_addr_t rom_mask_exp;
	logic                 hdr_exp;
	logic                 gg_exp;
	logic [31:0]          rng;
	int                   plain_k;
	int                   hdr_k;
	int                   limit;

	sms_cart_top UUT (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.gg             (gg),
		.rom_rd         (rom_rd),
		.rom_a          (rom_a),
		.rom_do         (rom_do),
		.rom_rdy        (rom_rdy)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Header images skip the first HDR_BYTES, then mirror into 2^k
	function automatic cart_pkg::cart_byte_t expected_byte(input cart_pkg::cart_addr_t a);
		cart_pkg::cart_addr_t idx;
		if (hdr_exp)
			idx = (a + `HDR_BYTES) & rom_mask_exp;
		else
			idx = a & rom_mask_exp;
		return model[idx];
	endfunction

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic value_mismatch(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic protocol_fault(input string msg);
		$display("Failure at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic watchdog(input int cycles);
		repeat (cycles) @(posedge clk_sys);
		protocol_fault($sformatf("run did not finish within %0d cycles", cycles));
	endtask

	// Index all ones is a cheat file, which the store never sees
	task automatic download_image(input logic [7:0] index, input int nbytes);
		int i;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (i = 0; i < nbytes; i++) begin
			rng = xorshift32(rng);
			if (index != 8'hff)
				model[i] = rng[7:0];
			ioctl_addr = cart_pkg::cart_addr_t'(i);
			ioctl_dout = rng[7:0];
			ioctl_wr   = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			@(negedge clk_sys);
			while (ioctl_wait)
				@(negedge clk_sys); // Next byte only after the fall
		end
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys); // Let has_hdr latch
	endtask

	task automatic read_burst(input int n, input int gap_max);
		int i;
		int gap;
		cart_pkg::cart_addr_t a;
		for (i = 0; i < n; i++) begin
			rng = xorshift32(rng);
			a = rng[`CART_AW-1:0];
			rom_a  = a;
			rom_rd = 1'b1;
			rd_exp.push_back(expected_byte(a));
			@(negedge clk_sys);
			rom_rd = 1'b0;
			rng = xorshift32(rng);
			gap = (gap_max > 0) ? int'(rng[7:0]) % (gap_max + 1) : 0;
			repeat (gap) @(negedge clk_sys);
		end
		while (rd_exp.size() != 0)
			@(negedge clk_sys);
	endtask

	task automatic read_phase();
		read_burst(burst_reads, 0); // One request every cycle
		read_burst(sparse_reads, 3);
	endtask

	// Front of the queue lines up with the rdy seen on the next edge
	always @(negedge clk_sys) begin
		if (rom_rdy) begin
			if (rd_exp.size() == 0)
				protocol_fault("rom_rdy arrived with no read outstanding");
			else
				exp_head = rd_exp.pop_front();
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	a_reset_quiet: assert property (@(posedge clk_sys)
		(!rst_n || $rose(rst_n)) |-> (!ioctl_wait && !rom_rdy && !gg))
		else value_mismatch("ioctl_wait, rom_rdy or gg not low around reset");

	a_wait_rises: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ioctl_wr && ioctl_download && !(&ioctl_index)) |=> ioctl_wait)
		else value_mismatch("ioctl_wait not raised after a cartridge byte");

	a_wait_falls: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(ioctl_wait) |-> ##[1:(`WR_ACK_LAT + 1)] !ioctl_wait)
		else protocol_fault("ioctl_wait stuck high, the store never acknowledged");

	a_cheat_no_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ioctl_download && (&ioctl_index)) |-> !ioctl_wait)
		else value_mismatch("ioctl_wait raised during a cheat download");

	a_cheat_gg: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ioctl_download && (&ioctl_index)) |=> $stable(gg))
		else value_mismatch("gg changed during a cheat download");

	a_gg_value: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!ioctl_download |-> (gg == gg_exp))
		else value_mismatch($sformatf("gg is %b, expected %b", $sampled(gg), $sampled(gg_exp)));

	a_rdy_latency: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_rd |-> ##(`RD_LAT + 2) rom_rdy)
		else protocol_fault("rom_rdy missing four cycles after rom_rd");

	a_rdy_origin: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_rdy |-> $past(rom_rd, `RD_LAT + 2))
		else protocol_fault("rom_rdy came without a request four cycles earlier");

	a_rdy_data: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_rdy |-> (rom_do == exp_head))
		else value_mismatch($sformatf("rom_do is %h, expected %h",
			$sampled(rom_do), $sampled(exp_head)));

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial begin
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_rd         = 1'b0;
		rom_a          = '0;
		exp_head       = '0;
		rom_mask_exp   = '0;
		hdr_exp        = 1'b0;
		gg_exp         = 1'b0;
		rng            = 32'h20d5;

		rng = xorshift32(rng);
		plain_k = 12 + int'(rng % 3); // 4 to 16 KiB
		rng = xorshift32(rng);
		hdr_k = 12 + int'(rng % 2);
		limit = ((1 << plain_k) + (1 << hdr_k) + `HDR_BYTES + cheat_bytes)
			* (`WR_ACK_LAT + 4) + read_phases * (burst_reads + sparse_reads) + 200;
		fork
			watchdog(limit);
		join_none

		repeat (8) @(negedge clk_sys);
		rst_n = 1'b1;
		repeat (4) @(negedge clk_sys);

		// Plain power-of-two image
		download_image(8'd1, 1 << plain_k);
		rom_mask_exp = cart_pkg::cart_addr_t'((1 << plain_k) - 1);
		read_phase();

		// Game Gear image behind a copier header
		gg_exp = 1'b1;
		download_image(8'(`GG_INDEX), (1 << hdr_k) + `HDR_BYTES);
		rom_mask_exp = cart_pkg::cart_addr_t'((1 << hdr_k) - 1);
		hdr_exp      = 1'b1;
		read_phase();

		download_image(8'hff, cheat_bytes);
		read_phase(); // Same image as before

		repeat (4) @(negedge clk_sys);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== source/cart_defs.svh ====
/* Cartridge path constants: address width, image header size and store latencies.
   Include wherever a width or latency is needed. */

`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// ======================================================================
// Cartridge space
// ======================================================================

`define CART_AW 16    // Byte address width, 64 KiB space
`define HDR_BYTES 512 // Optional copier header in front of the image

// ======================================================================
// Store timing
// ======================================================================

// Cycles from a write request toggle to the matching ack toggle
`define WR_ACK_LAT 4

`define RD_LAT 2 // Read pipeline depth of the store

// Download index, low five bits, that marks a Game Gear image
`define GG_INDEX 2

`endif

// ==== source/cart_loader.sv ====
/* Takes host download bytes, throttles them with ioctl_wait and writes them to
   the store, learning the image mask, header flag and Game Gear flag on the way. */

`timescale 1ns/1ps
`include "cart_defs.svh"

module cart_loader (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 ioctl_download,
	input  logic [7:0]           ioctl_index,
	input  logic                 ioctl_wr,
	input  cart_pkg::cart_addr_t ioctl_addr,
	input  cart_pkg::cart_byte_t ioctl_dout,
	output logic                 ioctl_wait,
	output logic                 gg,
	output cart_pkg::cart_geom_t geom,
	rom_write_if.loader          wr
);

	localparam cart_pkg::cart_addr_t hdr_off = cart_pkg::cart_addr_t'(`HDR_BYTES);
	localparam logic [4:0] gg_idx = 5'(`GG_INDEX);

	logic                 code_index;    // All ones index is a cheat file
	logic                 cart_download;
	logic                 old_download;
	logic                 dl_rise;
	logic                 dl_fall;
	logic                 accept;        // Byte taken this cycle
	logic                 write_done;
	logic                 req_q;
	cart_pkg::cart_addr_t waddr;         // Own store address counter
	cart_pkg::cart_byte_t wdata;
	cart_pkg::cart_addr_t end_addr;      // One past the last byte seen

	assign code_index    = &ioctl_index;
	assign cart_download = ioctl_download & ~code_index;
	assign dl_rise       = cart_download & ~old_download;
	assign dl_fall       = old_download & ~cart_download;
	assign accept        = ioctl_wr & cart_download;
	assign write_done    = ioctl_wait & (req_q == wr.ack);

	// ======================================================================
	// Write sequencing
	// ======================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			old_download <= 1'b0;
			ioctl_wait   <= 1'b0;
			req_q        <= 1'b0;
			waddr        <= '0;
		end else begin
			old_download <= cart_download;
			if (accept) begin
				ioctl_wait <= 1'b1;
				req_q      <= ~req_q; // Kick the store
			end else if (write_done) begin
				ioctl_wait <= 1'b0;
				waddr      <= waddr + 1'b1;
			end
			// New image always starts at the bottom of the store
			if (dl_rise)
				waddr <= '0;
		end
	end

	// Held until the store has taken it
	always_ff @(posedge clk_sys) begin
		if (accept)
			wdata <= ioctl_dout;
	end

	assign wr.req  = req_q;
	assign wr.addr = waddr;
	assign wr.data = wdata;

	// ======================================================================
	// Geometry learning
	// ======================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			geom     <= '0;
			gg       <= 1'b0;
			end_addr <= '0;
		end else begin
			if (accept) begin
				geom.mask <= (ioctl_addr == '0) ? '0 : (geom.mask | ioctl_addr);
				// Header bytes themselves land in the wrapped range and are
				// wiped when the first real ROM byte arrives
				geom.mask_hdr <= (ioctl_addr == hdr_off) ? '0 :
					(geom.mask_hdr | (ioctl_addr - hdr_off));
				end_addr <= ioctl_addr + 1'b1;
				gg       <= (ioctl_index[4:0] == gg_idx);
			end
			if (dl_fall)
				geom.has_hdr <= end_addr[9]; // Length 2^k + 512 sets bit 9
		end
	end

	// Host back-pressure contract across the whole write path
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wait |-> !ioctl_wr)
		else $error("host wrote a byte while ioctl_wait was high");

endmodule

// ==== source/cart_pkg.sv ====
/* Shared cartridge types: byte address, data byte and learned image geometry.
   Referenced by scoped name from the cartridge RTL. */

`include "cart_defs.svh"

package cart_pkg;

	// ======================================================================
	// Basic types
	// ======================================================================

	typedef logic [`CART_AW-1:0] cart_addr_t; // Byte address into the store
	typedef logic [7:0]          cart_byte_t;

	// ======================================================================
	// Image geometry learned during a download
	// ======================================================================

	// mask is the OR of every downloaded address, so for a power-of-two
	// image it ends up as size minus one.
	// mask_hdr does the same for addresses with the header stripped off,
	// starting from the first byte after the header.
	// has_hdr is set when the image length is an odd multiple of the
	// header size, which is how a copier header shows up.
	typedef struct packed {
		cart_addr_t mask;
		cart_addr_t mask_hdr;
		logic       has_hdr;
	} cart_geom_t;

endpackage

// ==== source/cart_reader.sv ====
/* Console side of the cartridge: maps ROM addresses through the learned mask
   and header offset, issues store reads and registers the returned byte. */

`timescale 1ns/1ps
`include "cart_defs.svh"

module cart_reader (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  cart_pkg::cart_geom_t geom,
	input  logic                 rom_rd,
	input  cart_pkg::cart_addr_t rom_a,
	output cart_pkg::cart_byte_t rom_do,
	output logic                 rom_rdy,
	rom_read_if.reader           rd
);

	localparam cart_pkg::cart_addr_t hdr_off = cart_pkg::cart_addr_t'(`HDR_BYTES);

	cart_pkg::cart_addr_t map_a; // Address after mirroring
	cart_pkg::cart_addr_t rd_a;
	logic                 rd_q;

	// Skip the copier header, then mirror into the image size
	always_comb begin
		if (geom.has_hdr)
			map_a = (rom_a + hdr_off) & geom.mask_hdr;
		else
			map_a = rom_a & geom.mask;
	end

	// ======================================================================
	// Request and response registers
	// ======================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_q    <= 1'b0;
			rom_rdy <= 1'b0;
		end else begin
			rd_q    <= rom_rd;
			rom_rdy <= rd.rdy;
		end
	end

	always_ff @(posedge clk_sys) begin
		rd_a   <= map_a;
		rom_do <= rd.data; // Only meaningful alongside rom_rdy
	end

	assign rd.rd   = rd_q;
	assign rd.addr = rd_a;

	// Store answers each request after exactly its pipeline depth
	a_rdy_follows_rd: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rd.rdy |-> $past(rd.rd, `RD_LAT))
		else $error("store returned data without a matching request");

endmodule

// ==== source/rom_read_if.sv ====
/* Read request and returned data between the ROM reader and cartridge storage.
   One rdy pulse comes back for every rd pulse, in order. */

`timescale 1ns/1ps

interface rom_read_if;

	logic                 rd;   // Single cycle request
	cart_pkg::cart_addr_t addr; // Already mapped through the geometry
	cart_pkg::cart_byte_t data;
	logic                 rdy;  // Data valid strobe

	modport reader (
		output rd,
		output addr,
		input  data,
		input  rdy
	);

	modport store (
		input  rd,
		input  addr,
		output data,
		output rdy
	);

endinterface

// ==== source/rom_store.sv ====
/* On-chip cartridge storage standing in for SDRAM. Writes come in on a toggle
   handshake with a fixed ack delay, reads return through a fixed pipeline. */

`timescale 1ns/1ps
`include "cart_defs.svh"

module rom_store (
	input  logic      clk_sys,
	input  logic      rst_n,
	rom_write_if.store wr,
	rom_read_if.store  rd
);

	localparam int depth = 1 << `CART_AW;

	cart_pkg::cart_byte_t   mem [depth];
	logic [`WR_ACK_LAT-1:0] ack_pipe;  // Toggle delay line
	logic                   wr_fire;
	logic [`RD_LAT-1:0]     rd_vld;
	cart_pkg::cart_byte_t   rd_dat [`RD_LAT];

	// First stage of the delay line doubles as the edge detector
	assign wr_fire = wr.req ^ ack_pipe[0];

	// ======================================================================
	// Memory array and read data path
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (wr_fire)
			mem[wr.addr] <= wr.data;
		rd_dat[0] <= mem[rd.addr];
		for (int i = 1; i < `RD_LAT; i++)
			rd_dat[i] <= rd_dat[i-1];
	end

	// ======================================================================
	// Handshake and valid tracking
	// ======================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ack_pipe <= '0;
			rd_vld   <= '0;
		end else begin
			ack_pipe <= {ack_pipe[`WR_ACK_LAT-2:0], wr.req};
			rd_vld   <= {rd_vld[`RD_LAT-2:0], rd.rd};
		end
	end

	assign wr.ack  = ack_pipe[`WR_ACK_LAT-1];
	assign rd.data = rd_dat[`RD_LAT-1];
	assign rd.rdy  = rd_vld[`RD_LAT-1];

	// Loader must wait for ack before the next byte
	a_one_write: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(wr.req != wr.ack) |=> $stable(wr.req))
		else $error("write request toggled while a write was outstanding");

endmodule

// ==== source/rom_write_if.sv ====
/* Toggle write handshake from the download loader into cartridge storage.
   A write is in flight while req and ack differ. */

`timescale 1ns/1ps

interface rom_write_if;

	logic                 req;  // Flips once per byte
	cart_pkg::cart_addr_t addr;
	cart_pkg::cart_byte_t data;
	logic                 ack;  // Follows req after the store latency

	modport loader (
		output req,
		output addr,
		output data,
		input  ack
	);

	modport store (
		input  req,
		input  addr,
		input  data,
		output ack
	);

endinterface

// ==== source/sms_cart_top.sv ====
/* Cartridge path top level for the Master System / Game Gear core.
   Joins the download loader, the ROM store and the console-side reader. */

`timescale 1ns/1ps

module sms_cart_top (
	input  logic                 clk_sys,
	input  logic                 rst_n,

	// Host download side
	input  logic                 ioctl_download,
	input  logic [7:0]           ioctl_index,
	input  logic                 ioctl_wr,
	input  cart_pkg::cart_addr_t ioctl_addr,
	input  cart_pkg::cart_byte_t ioctl_dout,
	output logic                 ioctl_wait,

	// Console side
	output logic                 gg,
	input  logic                 rom_rd,
	input  cart_pkg::cart_addr_t rom_a,
	output cart_pkg::cart_byte_t rom_do,
	output logic                 rom_rdy
);

	cart_pkg::cart_geom_t geom;

	rom_write_if wr_bus ();
	rom_read_if  rd_bus ();

	cart_loader u_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.gg             (gg),
		.geom           (geom),
		.wr             (wr_bus.loader)
	);

	rom_store u_store (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wr      (wr_bus.store),
		.rd      (rd_bus.store)
	);

	cart_reader u_reader (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.geom    (geom),
		.rom_rd  (rom_rd),
		.rom_a   (rom_a),
		.rom_do  (rom_do),
		.rom_rdy (rom_rdy),
		.rd      (rd_bus.reader)
	);

endmodule

// ==== vlog.f ====
+incdir+source
source/cart_pkg.sv
source/rom_write_if.sv
source/rom_read_if.sv
source/cart_loader.sv
source/rom_store.sv
source/cart_reader.sv
source/sms_cart_top.sv
bench/tb_sms_cart.sv
